/* src.f */
logic/cachePkg.sv
logic/cacheArray.sv
logic/cacheControl.sv
logic/lineFillBuffer.sv
logic/lineWriteBuffer.sv
logic/dataCache.sv
verification/memoryModel.sv
verification/cacheTb.sv

/* Bender.yml */
package:
  name: data_cache

sources:
  - files:
      - logic/cachePkg.sv
      - logic/cacheArray.sv
      - logic/cacheControl.sv
      - logic/lineFillBuffer.sv
      - logic/lineWriteBuffer.sv
      - logic/dataCache.sv
  - target: test
    files:
      - verification/memoryModel.sv
      - verification/cacheTb.sv

/* verification/cacheTb.sv */
`timescale 1ns/100ps

module cacheTb;
    import cachePkg::*;

    localparam int   memLatency    = 4;
    localparam int   numAccesses   = 8;
    localparam int   clkPeriod     = 100;
    localparam int   timeoutCycles = numAccesses * (memLatency + 2 * wordsPerLine + 10);
    localparam addrT windowMask    = 32'h0003_FFE0;    // Line aligned within the model window

    logic   Clk;
    logic   rstN;
    cpuReqT cpuReq;
    wordT   rdData;
    logic   stall;
    logic   memRdReq;
    addrT   memRdAddr;
    logic   memRdValid;
    wordT   memRdData;
    memWrT  memWr;

    int   errors        = 0;
    int   checks        = 0;
    int   rdReqCount    = 0;
    int   wrStrobeCount = 0;
    addrT lastRdAddr    = '0;           // Address of the latest memory read request
    addrT storeAddr [16];               // Stores in the order they were made
    wordT storeData [16];
    int   storeCount    = 0;

    dataCache dut (
        .Clk, .rstN, .cpuReq, .rdData, .stall,
        .memRdReq, .memRdAddr, .memRdValid, .memRdData, .memWr
    );

    memoryModel #(.memLatency(memLatency)) mem (
        .Clk, .rdReq(memRdReq), .rdAddr(memRdAddr),
        .rdValid(memRdValid), .rdData(memRdData), .wr(memWr)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    // Memory traffic counted mid-cycle
    always @(negedge Clk) begin
        if (memRdReq) begin
            rdReqCount++;
            lastRdAddr = memRdAddr;
        end
        if (memWr.valid) begin
            wrStrobeCount++;
        end
    end

    initial begin
        #(clkPeriod * timeoutCycles);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", timeoutCycles);
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////
    function automatic wordT expectedWord(addrT a);
        addrT aligned;
        wordT value;
        aligned = {a[31:2], 2'b00};
        value   = aligned ^ 32'hA5A5_0000;     // Memory contents nobody stored to
        for (int i = 0; i < storeCount; i++) begin
            if (storeAddr[i] == aligned) begin
                value = storeData[i];
            end
        end
        return value;
    endfunction

    function automatic addrT pickWord(addrT line);
        return line | addrT'(($urandom % wordsPerLine) * 4);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0d ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Failure at %0d ns: %s", $time, what);
        end
    endtask

    // One processor access held until stall drops
    task automatic access(input logic rw, input addrT a, input wordT d,
                          output wordT rd, output int stallCycles);
        @(negedge Clk);
        cpuReq.en     = 1'b1;
        cpuReq.rw     = rw;
        cpuReq.addr   = a;
        cpuReq.wrData = d;
        stallCycles   = 0;
        #1;
        while (stall) begin
            @(negedge Clk);
            #1;
            stallCycles++;
        end
        rd = rdData;                    // Access completes at the next rising edge
        if (rw) begin
            storeAddr[storeCount] = {a[31:2], 2'b00};
            storeData[storeCount] = d;
            storeCount++;
        end
        @(negedge Clk);
        cpuReq.en = 1'b0;
    endtask

    // Background refill and write-back drain followed by the install cycle
    task automatic waitIdle();
        @(negedge Clk);
        while (memRdValid || memWr.valid) begin
            @(negedge Clk);
        end
        @(negedge Clk);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////
    task automatic idleAfterReset();
        #1;
        checkValue("stall", stall, 1'b0);
        checkValue("memRdReq", memRdReq, 1'b0);
        checkValue("memWr.valid", memWr.valid, 1'b0);
    endtask

    task automatic readMissThenHit(input addrT line);
        addrT a;
        wordT rd;
        int   stallCycles;
        int   reqBefore;
        a         = pickWord(line);
        reqBefore = rdReqCount;
        access(1'b0, a, '0, rd, stallCycles);
        checkValue("rdData", rd, expectedWord(a));
        checkValue("memRdAddr", lastRdAddr, {a[31:2], 2'b00});
        checkTrue(stallCycles == memLatency + 1,
                  $sformatf("read miss released after %0d stall cycles, expected %0d",
                            stallCycles, memLatency + 1));
        waitIdle();
        checkTrue(rdReqCount == reqBefore + 1, "read miss did not issue one memory request");
        a         = pickWord(line);
        reqBefore = rdReqCount;
        access(1'b0, a, '0, rd, stallCycles);
        checkValue("rdData", rd, expectedWord(a));
        checkTrue(stallCycles == 0, $sformatf("read hit stalled for %0d cycles", stallCycles));
        waitIdle();
        checkTrue(rdReqCount == reqBefore, "read hit issued a memory request");
    endtask

    task automatic writeHitThenRead(input addrT line);
        addrT a;
        wordT rd;
        int   stallCycles;
        a = pickWord(line);
        access(1'b1, a, $urandom, rd, stallCycles);
        checkTrue(stallCycles == 0, $sformatf("write hit stalled for %0d cycles", stallCycles));
        access(1'b0, a, '0, rd, stallCycles);
        checkValue("rdData", rd, expectedWord(a));
    endtask

    task automatic dirtyEviction(input addrT oldLine, input addrT newLine);
        addrT a;
        wordT rd;
        wordT memWord;
        int   stallCycles;
        int   strobesBefore;
        a             = pickWord(newLine);
        strobesBefore = wrStrobeCount;
        access(1'b0, a, '0, rd, stallCycles);
        checkValue("rdData", rd, expectedWord(a));
        waitIdle();
        checkValue("memWr strobes", wrStrobeCount - strobesBefore, wordsPerLine);
        for (int i = 0; i < wordsPerLine; i++) begin
            mem.readWord(oldLine + addrT'(4 * i), memWord);
            checkValue($sformatf("mem[0x%h]", oldLine + addrT'(4 * i)), memWord,
                       expectedWord(oldLine + addrT'(4 * i)));
        end
    endtask

    task automatic writeMissThenRead(input addrT line);
        addrT a;
        wordT rd;
        int   stallCycles;
        a = pickWord(line);
        access(1'b1, a, $urandom, rd, stallCycles);
        checkTrue(stallCycles > 0, "write miss completed without a stall");
        access(1'b0, a, '0, rd, stallCycles);
        checkValue("rdData", rd, expectedWord(a));
        access(1'b0, a ^ 32'h4, '0, rd, stallCycles);     // Neighbour in the same line
        checkValue("rdData", rd, expectedWord(a ^ 32'h4));
    endtask

    initial begin
        addrT lineA;
        addrT lineB;
        addrT lineC;
        void'($urandom(65076));
        cpuReq = '0;
        rstN   = 1'b0;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        rstN  = 1'b1;
        lineA = $urandom & windowMask;
        lineB = lineA ^ 32'h0001_0000;         // Same index but another tag
        lineC = lineA ^ 32'h0000_0400;         // Other index
        idleAfterReset();
        readMissThenHit(lineA);
        writeHitThenRead(lineA);
        dirtyEviction(lineA, lineB);
        writeMissThenRead(lineC);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verification/memoryModel.sv */
`timescale 1ns/100ps

module memoryModel #(
    parameter int memLatency = 4        // Request strobe to first word, at least 2
) (
    input  logic            Clk,
    input  logic            rdReq,
    input  cachePkg::addrT  rdAddr,
    output logic            rdValid,
    output cachePkg::wordT  rdData,
    input  cachePkg::memWrT wr
);
    import cachePkg::*;

    localparam int memAddrBits = 16;    // 256 KiB window of word storage

    wordT mem [2**memAddrBits];
    addrT burstAddr;
    int   beatCnt;
    int   waitCnt;
    logic bursting;

    // Word index of beat n, wrapping inside the line
    function automatic logic [memAddrBits-1:0] wordIndex(addrT base, int beat);
        offsetT off;
        off = addrOffset(base) + offsetT'(beat);
        return {base[memAddrBits+1:5], off};
    endfunction

    task automatic readWord(input addrT a, output wordT d);
        d = mem[a[memAddrBits+1:2]];
    endtask

    initial begin
        for (int i = 0; i < 2**memAddrBits; i++) begin
            mem[i] = wordT'(i * 4) ^ 32'hA5A5_0000;   // Own byte address, scrambled
        end
        rdValid  = 1'b0;
        rdData   = '0;
        bursting = 1'b0;
    end

    always @(posedge Clk) begin
        rdValid <= 1'b0;
        if (wr.valid) begin
            mem[wr.addr[memAddrBits+1:2]] <= wr.data;
        end
        if (rdReq) begin
            burstAddr <= rdAddr;
            beatCnt   <= 0;
            waitCnt   <= memLatency - 1;
            bursting  <= 1'b1;
        end else if (bursting) begin
            if (waitCnt > 1) begin
                waitCnt <= waitCnt - 1;
            end else begin
                rdValid <= 1'b1;             // One beat per cycle from here on
                rdData  <= mem[wordIndex(burstAddr, beatCnt)];
                beatCnt <= beatCnt + 1;
                if (beatCnt == wordsPerLine - 1) begin
                    bursting <= 1'b0;
                end
            end
        end
    end

endmodule

/* logic/dataCache.sv */
`timescale 1ns/100ps

module dataCache (
    input  logic             Clk,
    input  logic             rstN,
    input  cachePkg::cpuReqT cpuReq,
    output cachePkg::wordT   rdData,
    output logic             stall,
    output logic             memRdReq,
    output cachePkg::addrT   memRdAddr,
    input  logic             memRdValid,
    input  cachePkg::wordT   memRdData,
    output cachePkg::memWrT  memWr
);
    import cachePkg::*;

    logic  hit;
    logic  victimDirty;
    tagT   victimTag;
    lineT  victimLine;
    wordT  arrayRdWord;
    logic  firstWord;
    logic  fillDone;
    wordT  critData;
    lineT  fillLine;
    indexT fillIndex;
    logic  evictDone;
    logic  fillStart;
    logic  evictStart;
    logic  arrayWrWord;
    logic  arrayWrLine;
    logic  lineDirty;
    logic  critWord;
    logic  mergeWord;

    // Critical word bypasses the array on a read miss
    assign rdData = critWord ? critData : arrayRdWord;

    cacheControl control (
        .Clk, .rstN, .cpuReq, .hit, .victimDirty, .firstWord, .fillDone, .evictDone,
        .fillIndex, .stall, .fillStart, .evictStart, .arrayWrWord, .arrayWrLine,
        .lineDirty, .critWord, .mergeWord
    );

    // Line installs use the fill address, the processor may have moved on
    cacheArray array (
        .Clk, .rstN,
        .addr        (arrayWrLine ? memRdAddr : cpuReq.addr),
        .wrWord      (arrayWrWord),
        .wrLine      (arrayWrLine),
        .lineDirty,
        .wrData      (cpuReq.wrData),
        .lineIn      (fillLine),
        .hit, .victimDirty, .victimTag, .victimLine,
        .rdWord      (arrayRdWord)
    );

    lineFillBuffer fillBuf (
        .Clk, .rstN,
        .start     (fillStart),
        .reqAddr   (cpuReq.addr),
        .mergeEn   (mergeWord),
        .mergeData (cpuReq.wrData),
        .memRdReq, .memRdAddr, .memRdValid, .memRdData, .firstWord,
        .done      (fillDone),
        .critData,
        .line      (fillLine),
        .index     (fillIndex)
    );

    lineWriteBuffer writeBuf (
        .Clk, .rstN,
        .start      (evictStart),
        .victimAddr ({victimTag, addrIndex(cpuReq.addr), 5'b00000}),
        .victimLine,
        .memWr,
        .done       (evictDone)
    );

endmodule

/* logic/lineWriteBuffer.sv */
`timescale 1ns/100ps

module lineWriteBuffer (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            start,
    input  cachePkg::addrT  victimAddr,
    input  cachePkg::lineT  victimLine,
    output cachePkg::memWrT memWr,
    output logic            done
);
    import cachePkg::*;

    logic   active;
    offsetT wordCnt;
    tagT    tagQ;
    indexT  indexQ;
    lineT   lineQ;

    assign done = active && (wordCnt == offsetT'(wordsPerLine - 1));

    // Words 0..7 in order, one per cycle
    always_comb begin
        memWr.valid = active;
        memWr.addr  = {tagQ, indexQ, wordCnt, 2'b00};
        memWr.data  = lineQ[wordCnt];
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            active  <= 1'b0;
            wordCnt <= '0;
        end else if (start) begin
            active  <= 1'b1;
            wordCnt <= '0;
        end else if (active) begin
            wordCnt <= wordCnt + 1'b1;
            if (done) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            tagQ   <= addrTag(victimAddr);
            indexQ <= addrIndex(victimAddr);
            lineQ  <= victimLine;
        end
    end

endmodule

/* logic/lineFillBuffer.sv */
`timescale 1ns/100ps

module lineFillBuffer (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            start,
    input  cachePkg::addrT  reqAddr,
    input  logic            mergeEn,
    input  cachePkg::wordT  mergeData,
    output logic            memRdReq,
    output cachePkg::addrT  memRdAddr,
    input  logic            memRdValid,
    input  cachePkg::wordT  memRdData,
    output logic            firstWord,
    output logic            done,
    output cachePkg::wordT  critData,
    output cachePkg::lineT  line,
    output cachePkg::indexT index
);
    import cachePkg::*;

    logic   busy;
    logic   memRdReqQ;
    offsetT wordCnt;     // Words received so far
    offsetT critOffset;
    offsetT slot;
    addrT   reqAddrQ;
    lineT   lineQ;

    assign slot      = critOffset + wordCnt;    // Wraps within the line
    assign firstWord = busy && memRdValid && (wordCnt == '0);
    assign done      = busy && memRdValid && (wordCnt == offsetT'(wordsPerLine - 1));
    assign critData  = memRdData;

    assign memRdReq  = memRdReqQ;
    assign memRdAddr = reqAddrQ;
    assign line      = lineQ;
    assign index     = addrIndex(reqAddrQ);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            busy      <= 1'b0;
            memRdReqQ <= 1'b0;
            wordCnt   <= '0;
        end else begin
            memRdReqQ <= start;         // One-cycle request strobe
            if (start) begin
                busy    <= 1'b1;
                wordCnt <= '0;
            end else if (busy && memRdValid) begin
                wordCnt <= wordCnt + 1'b1;
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            reqAddrQ   <= {reqAddr[31:2], 2'b00};
            critOffset <= addrOffset(reqAddr);
        end
        if (busy && memRdValid) begin
            // Store data replaces the critical word on a write miss
            lineQ[slot] <= (firstWord && mergeEn) ? mergeData : memRdData;
        end
    end

endmodule

/* logic/cacheControl.sv */
`timescale 1ns/100ps

module cacheControl (
    input  logic             Clk,
    input  logic             rstN,
    input  cachePkg::cpuReqT cpuReq,
    input  logic             hit,
    input  logic             victimDirty,
    input  logic             firstWord,
    input  logic             fillDone,
    input  logic             evictDone,
    input  cachePkg::indexT  fillIndex,
    output logic             stall,
    output logic             fillStart,
    output logic             evictStart,
    output logic             arrayWrWord,
    output logic             arrayWrLine,
    output logic             lineDirty,
    output logic             critWord,
    output logic             mergeWord
);
    import cachePkg::*;

    readStateT  readState;
    writeStateT writeState;

    // Outstanding buffer work, one pair per state machine
    logic rdFillPend;
    logic rdEvictPend;
    logic wrFillPend;
    logic wrEvictPend;

    logic readMissing;  // Waiting for the critical word
    logic readWaiting;  // Processor released, line still filling
    logic sameLine;
    logic missStart;
    logic rdStart;
    logic wrStart;

    assign readMissing = readState inside {readMissDirty, readMissClean};
    assign readWaiting = readState inside {waitDirty, waitClean};

    // Access to the index whose line is still arriving
    assign sameLine = readWaiting && (addrIndex(cpuReq.addr) == fillIndex);

    // A miss may only launch the buffers when both machines are free
    assign missStart = cpuReq.en && !hit &&
                       (readState == readIdle) && (writeState == writeIdle);
    assign rdStart   = missStart && !cpuReq.rw;
    assign wrStart   = missStart && cpuReq.rw;

    ////////////////////////////////////////////////////////////////////
    // Processor side
    ////////////////////////////////////////////////////////////////////
    assign stall = cpuReq.en && (
                       (readMissing && !firstWord) ||                // Critical word pending
                       (readState == writeLine) ||                   // Array busy installing
                       sameLine ||
                       (!hit && !readMissing) ||                     // New or second miss
                       (cpuReq.rw && (writeState != writeIdle))      // Store still pending
                   );

    assign critWord    = readMissing && firstWord;
    assign arrayWrWord = cpuReq.en && cpuReq.rw && hit && !stall;
    assign arrayWrLine = (readState == writeLine) || (writeState == mergeLine);
    assign lineDirty   = (writeState == mergeLine);   // Merged store makes the line dirty
    assign mergeWord   = writeState inside {fetchEvict, fetchOnly};

    assign fillStart  = missStart;
    assign evictStart = missStart && victimDirty;

    ////////////////////////////////////////////////////////////////////
    // Read miss FSM
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            readState   <= readIdle;
            rdFillPend  <= 1'b0;
            rdEvictPend <= 1'b0;
        end else begin
            case (readState)
                readIdle: begin
                    if (rdStart) begin
                        readState   <= victimDirty ? readMissDirty : readMissClean;
                        rdFillPend  <= 1'b1;
                        rdEvictPend <= victimDirty;
                    end
                end
                readMissDirty: begin
                    // Write-back can finish before a slow critical word
                    if (evictDone) begin
                        rdEvictPend <= 1'b0;
                    end
                    if (firstWord) begin
                        readState <= waitDirty;
                    end
                end
                readMissClean: begin
                    if (firstWord) begin
                        readState <= waitClean;
                    end
                end
                waitDirty: begin
                    if (fillDone) begin
                        rdFillPend <= 1'b0;
                    end
                    if (evictDone) begin
                        rdEvictPend <= 1'b0;
                    end
                    if ((fillDone || !rdFillPend) && (evictDone || !rdEvictPend)) begin
                        readState <= writeLine;
                    end
                end
                waitClean: begin
                    if (fillDone || !rdFillPend) begin
                        rdFillPend <= 1'b0;
                        readState  <= writeLine;
                    end
                end
                writeLine: readState <= readIdle;    // Line goes into the array here
                default:   readState <= readIdle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Write miss FSM
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            writeState  <= writeIdle;
            wrFillPend  <= 1'b0;
            wrEvictPend <= 1'b0;
        end else begin
            case (writeState)
                writeIdle: begin
                    if (cpuReq.en && cpuReq.rw && sameLine) begin
                        writeState <= wordOnCache;
                    end else if (wrStart) begin
                        writeState  <= victimDirty ? fetchEvict : fetchOnly;
                        wrFillPend  <= 1'b1;
                        wrEvictPend <= victimDirty;
                    end
                end
                wordOnCache: begin
                    // Retry once the refilled line is in the array
                    if (!sameLine) begin
                        writeState <= writeIdle;
                    end
                end
                fetchEvict: begin
                    if (fillDone) begin
                        wrFillPend <= 1'b0;
                    end
                    if (evictDone) begin
                        wrEvictPend <= 1'b0;
                    end
                    if ((fillDone || !wrFillPend) && (evictDone || !wrEvictPend)) begin
                        writeState <= mergeLine;
                    end
                end
                fetchOnly: begin
                    if (fillDone || !wrFillPend) begin
                        wrFillPend <= 1'b0;
                        writeState <= mergeLine;
                    end
                end
                mergeLine: writeState <= writeIdle;
                default:   writeState <= writeIdle;
            endcase
        end
    end

endmodule

/* logic/cacheArray.sv */
`timescale 1ns/100ps

module cacheArray (
    input  logic            Clk,
    input  logic            rstN,
    input  cachePkg::addrT  addr,
    input  logic            wrWord,
    input  logic            wrLine,
    input  logic            lineDirty,
    input  cachePkg::wordT  wrData,
    input  cachePkg::lineT  lineIn,
    output logic            hit,
    output logic            victimDirty,
    output cachePkg::tagT   victimTag,
    output cachePkg::lineT  victimLine,
    output cachePkg::wordT  rdWord
);
    import cachePkg::*;

    tagT  tagMem  [numLines];
    lineT dataMem [numLines];
    logic [numLines-1:0] validBits;
    logic [numLines-1:0] dirtyBits;

    tagT    tag;
    indexT  idx;
    offsetT off;

    assign tag = addrTag(addr);
    assign idx = addrIndex(addr);
    assign off = addrOffset(addr);

    ////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////
    assign hit         = validBits[idx] && (tagMem[idx] == tag);
    assign victimDirty = validBits[idx] && dirtyBits[idx];
    assign victimTag   = tagMem[idx];
    assign victimLine  = dataMem[idx];
    assign rdWord      = dataMem[idx][off];

    ////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (wrLine) begin
            validBits[idx] <= 1'b1;
            dirtyBits[idx] <= lineDirty;
        end else if (wrWord) begin
            dirtyBits[idx] <= 1'b1;     // Store hit, line now differs from memory
        end
    end

    always_ff @(posedge Clk) begin
        if (wrLine) begin
            tagMem[idx]  <= tag;
            dataMem[idx] <= lineIn;
        end else if (wrWord) begin
            dataMem[idx][off] <= wrData;
        end
    end

endmodule

/* logic/cachePkg.sv */
package cachePkg;

    ////////////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////////////
    localparam int wordsPerLine = 8;
    localparam int numLines     = 128;  // 4 KiB with 32-byte lines

    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;         // Byte address
    typedef logic [19:0] tagT;          // Address bits 31..12
    typedef logic [6:0]  indexT;        // Address bits 11..5
    typedef logic [2:0]  offsetT;       // Word within the line, bits 4..2

    typedef wordT [wordsPerLine-1:0] lineT;

    // Processor request, held stable while stall is high
    typedef struct packed {
        logic en;
        logic rw;                       // 1 for a store
        addrT addr;
        wordT wrData;
    } cpuReqT;

    // One word of a victim write-back
    typedef struct packed {
        logic valid;
        addrT addr;
        wordT data;
    } memWrT;

    typedef enum logic [2:0] {
        readIdle, readMissDirty, readMissClean, waitDirty, waitClean, writeLine
    } readStateT;

    typedef enum logic [2:0] {
        writeIdle, wordOnCache, fetchEvict, fetchOnly, mergeLine
    } writeStateT;

    // Address field helpers
    function automatic tagT addrTag(addrT a);
        return a[31:12];
    endfunction

    function automatic indexT addrIndex(addrT a);
        return a[11:5];
    endfunction

    function automatic offsetT addrOffset(addrT a);
        return a[4:2];
    endfunction

endpackage
